// ==== hdl/cpu_pkg.sv ====
// CPU package
// Shared widths, MIPS opcode encodings, the instruction word views
// and the structs that carry each pipeline stage

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;

    localparam addr_t RESET_PC   = 32'hBFC0_0000;
    localparam int    INST_BYTES = 4;
    localparam int    NUM_REGS   = 32;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } op_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    ////////////////////
    // Instruction word, seen as R-type or I-type
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_inst_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_inst_t;

    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_u;

    ////////////////////
    // Stage payloads
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_u inst;
    } fetch_t;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        alu_op_e    alu_op;
        word_t      src_a;
        word_t      src_b;
        logic [4:0] shamt;
        logic       we;
        reg_addr_t  waddr;
    } issue_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } commit_t;

endpackage

// ==== hdl/fetch_stage.sv ====
// Fetch stage
// Holds the PC, requests instructions from the I-cache and
// registers each accepted word with its address

`timescale 1ns/100ps

module fetch_stage (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             inst_stall_i,
    input  cpu_pkg::word_t   inst_i,
    output logic             inst_req_o,
    output cpu_pkg::addr_t   inst_addr_o,
    output cpu_pkg::fetch_t  fetch_o
);

    logic           started_q;
    logic           accept;
    cpu_pkg::addr_t pc_q;
    logic           fetch_valid_q;
    cpu_pkg::addr_t fetch_pc_q;
    cpu_pkg::inst_u fetch_inst_q;

    // No request on the first cycle out of reset
    assign inst_req_o  = started_q;
    assign inst_addr_o = pc_q;
    assign accept      = inst_req_o & ~inst_stall_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            started_q     <= 1'b0;
            pc_q          <= cpu_pkg::RESET_PC;
            fetch_valid_q <= 1'b0;
        end else begin
            started_q     <= 1'b1;
            fetch_valid_q <= accept;
            if (accept) begin
                pc_q <= pc_q + cpu_pkg::addr_t'(cpu_pkg::INST_BYTES);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_pc_q   <= pc_q;
            fetch_inst_q <= inst_i;
        end
    end

    assign fetch_o = '{valid: fetch_valid_q, pc: fetch_pc_q, inst: fetch_inst_q};

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i) inst_addr_o[1:0] == 2'b00
    );

endmodule

// ==== hdl/decode_stage.sv ====
// Decode stage
// Decodes the ALU subset, resolves source operands through
// forwarding and registers the result for execute

`timescale 1ns/100ps

module decode_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  cpu_pkg::fetch_t    fetch_i,
    output cpu_pkg::reg_addr_t rf_raddr_a_o,
    output cpu_pkg::reg_addr_t rf_raddr_b_o,
    input  cpu_pkg::word_t     rf_rdata_a_i,
    input  cpu_pkg::word_t     rf_rdata_b_i,
    input  cpu_pkg::commit_t   ex_fwd_i,
    input  cpu_pkg::commit_t   commit_i,
    output cpu_pkg::issue_t    issue_o
);

    cpu_pkg::inst_u     inst;
    cpu_pkg::word_t     rs_val;
    cpu_pkg::word_t     rt_val;
    cpu_pkg::alu_op_e   alu_op;
    logic               dec_we;
    cpu_pkg::reg_addr_t dest;
    cpu_pkg::word_t     src_b;
    cpu_pkg::issue_t    issue_d;
    cpu_pkg::issue_t    issue_q;
    logic               issue_valid_q;

    ////////////////////
    // Operand forwarding
    function automatic cpu_pkg::word_t fwd_operand(
        input cpu_pkg::reg_addr_t addr,
        input cpu_pkg::word_t     rf_data,
        input cpu_pkg::commit_t   ex,
        input cpu_pkg::commit_t   cm
    );
        if (addr == '0) begin
            return '0;
        end
        // Youngest producer wins
        if (ex.valid && ex.we && ex.waddr == addr) begin
            return ex.wdata;
        end
        if (cm.valid && cm.we && cm.waddr == addr) begin
            return cm.wdata;
        end
        return rf_data;
    endfunction

    assign inst         = fetch_i.inst;
    assign rf_raddr_a_o = inst.r.rs;
    assign rf_raddr_b_o = inst.r.rt;

    assign rs_val = fwd_operand(inst.r.rs, rf_rdata_a_i, ex_fwd_i, commit_i);
    assign rt_val = fwd_operand(inst.r.rt, rf_rdata_b_i, ex_fwd_i, commit_i);

    ////////////////////
    // Instruction decode
    always_comb begin
        alu_op = cpu_pkg::ALU_NOP;
        dec_we = 1'b0;
        dest   = inst.r.rd;
        src_b  = rt_val;
        case (inst.r.opcode)
            cpu_pkg::OP_SPECIAL: begin
                dec_we = 1'b1;
                case (inst.r.funct)
                    cpu_pkg::FN_SLL:  alu_op = cpu_pkg::ALU_SLL;
                    cpu_pkg::FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_XOR:  alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FN_SLT:  alu_op = cpu_pkg::ALU_SLT;
                    default:          dec_we = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                alu_op = cpu_pkg::ALU_ADD;
                dec_we = 1'b1;
                dest   = inst.i.rt;
                src_b  = {{16{inst.i.imm16[15]}}, inst.i.imm16};
            end
            cpu_pkg::OP_ORI: begin
                alu_op = cpu_pkg::ALU_OR;
                dec_we = 1'b1;
                dest   = inst.i.rt;
                src_b  = {16'h0000, inst.i.imm16};
            end
            cpu_pkg::OP_LUI: begin
                alu_op = cpu_pkg::ALU_LUI;
                dec_we = 1'b1;
                dest   = inst.i.rt;
                src_b  = {inst.i.imm16, 16'h0000};
            end
            default: begin
                dest = inst.i.rt;
            end
        endcase
        // r0 is never written
        if (dest == '0) begin
            dec_we = 1'b0;
        end
    end

    assign issue_d = '{
        valid:  fetch_i.valid,
        pc:     fetch_i.pc,
        alu_op: alu_op,
        src_a:  rs_val,
        src_b:  src_b,
        shamt:  inst.r.shamt,
        we:     dec_we & fetch_i.valid,
        waddr:  dest
    };

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= issue_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        issue_q <= issue_d;
    end

    always_comb begin
        issue_o       = issue_q;
        issue_o.valid = issue_valid_q;
    end

endmodule

// ==== hdl/regfile.sv ====
// General register file
// 32 x 32-bit, two combinational reads and one write from commit

`timescale 1ns/100ps

module regfile (
    input  logic               clk,
    input  logic               arst_n_i,
    input  cpu_pkg::commit_t   commit_i,
    input  cpu_pkg::reg_addr_t raddr_a_i,
    input  cpu_pkg::reg_addr_t raddr_b_i,
    output cpu_pkg::word_t     rdata_a_o,
    output cpu_pkg::word_t     rdata_b_o
);

    cpu_pkg::word_t regs_q [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit_i.valid && commit_i.we) begin
            regs_q[commit_i.waddr] <= commit_i.wdata;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    // Decode must have dropped every r0 destination
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (commit_i.valid && commit_i.we) |-> commit_i.waddr != '0
    );

endmodule

// ==== hdl/exec_stage.sv ====
// Execute stage
// ALU for the integer subset, exec forward port and the commit
// register feeding writeback and the trace outputs

`timescale 1ns/100ps

module exec_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  cpu_pkg::issue_t   issue_i,
    output cpu_pkg::commit_t  ex_fwd_o,
    output cpu_pkg::commit_t  commit_o
);

    cpu_pkg::word_t     alu_res;
    logic               commit_valid_q;
    logic               commit_we_q;
    cpu_pkg::addr_t     commit_pc_q;
    cpu_pkg::reg_addr_t commit_waddr_q;
    cpu_pkg::word_t     commit_wdata_q;

    ////////////////////
    // ALU
    always_comb begin
        case (issue_i.alu_op)
            cpu_pkg::ALU_ADD: alu_res = issue_i.src_a + issue_i.src_b;
            cpu_pkg::ALU_SUB: alu_res = issue_i.src_a - issue_i.src_b;
            cpu_pkg::ALU_AND: alu_res = issue_i.src_a & issue_i.src_b;
            cpu_pkg::ALU_OR:  alu_res = issue_i.src_a | issue_i.src_b;
            cpu_pkg::ALU_XOR: alu_res = issue_i.src_a ^ issue_i.src_b;
            cpu_pkg::ALU_SLT: begin
                alu_res = {31'b0, $signed(issue_i.src_a) < $signed(issue_i.src_b)};
            end
            cpu_pkg::ALU_SLL: alu_res = issue_i.src_b << issue_i.shamt;
            // Immediate already placed in the upper half by decode
            cpu_pkg::ALU_LUI: alu_res = issue_i.src_b;
            default:          alu_res = '0;
        endcase
    end

    // Write enable arrives already qualified by decode
    assign ex_fwd_o = '{
        valid: issue_i.valid,
        pc:    issue_i.pc,
        we:    issue_i.we,
        waddr: issue_i.waddr,
        wdata: alu_res
    };

    ////////////////////
    // Commit register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_valid_q <= 1'b0;
            commit_we_q    <= 1'b0;
        end else begin
            commit_valid_q <= ex_fwd_o.valid;
            commit_we_q    <= ex_fwd_o.we;
        end
    end

    always_ff @(posedge clk) begin
        commit_pc_q    <= ex_fwd_o.pc;
        commit_waddr_q <= ex_fwd_o.waddr;
        commit_wdata_q <= ex_fwd_o.wdata;
    end

    assign commit_o = '{
        valid: commit_valid_q,
        pc:    commit_pc_q,
        we:    commit_we_q,
        waddr: commit_waddr_q,
        wdata: commit_wdata_q
    };

    a_we_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i) commit_o.we |-> commit_o.valid
    );

endmodule

// ==== hdl/cpu_top.sv ====
// CPU top level
// Scalar in-order integer core: fetch, decode with operand fetch,
// execute and commit, around one general register file

`timescale 1ns/100ps

module cpu_top (
    input  logic            clk,
    input  logic            arst_n_i,
    output logic            inst_req_o,
    output cpu_pkg::addr_t  inst_addr_o,
    input  cpu_pkg::word_t  inst_i,
    input  logic            inst_stall_i,
    output cpu_pkg::commit_t commit_o
);

    cpu_pkg::fetch_t    fetch_w;
    cpu_pkg::issue_t    issue_w;
    cpu_pkg::commit_t   ex_fwd_w;
    cpu_pkg::reg_addr_t rf_raddr_a_w;
    cpu_pkg::reg_addr_t rf_raddr_b_w;
    cpu_pkg::word_t     rf_rdata_a_w;
    cpu_pkg::word_t     rf_rdata_b_w;

    fetch_stage u_fetch (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_stall_i (inst_stall_i),
        .inst_i       (inst_i),
        .inst_req_o   (inst_req_o),
        .inst_addr_o  (inst_addr_o),
        .fetch_o      (fetch_w)
    );

    decode_stage u_decode (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .fetch_i      (fetch_w),
        .rf_raddr_a_o (rf_raddr_a_w),
        .rf_raddr_b_o (rf_raddr_b_w),
        .rf_rdata_a_i (rf_rdata_a_w),
        .rf_rdata_b_i (rf_rdata_b_w),
        .ex_fwd_i     (ex_fwd_w),
        .commit_i     (commit_o),
        .issue_o      (issue_w)
    );

    regfile u_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .commit_i  (commit_o),
        .raddr_a_i (rf_raddr_a_w),
        .raddr_b_i (rf_raddr_b_w),
        .rdata_a_o (rf_rdata_a_w),
        .rdata_b_o (rf_rdata_b_w)
    );

    exec_stage u_exec (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .issue_i  (issue_w),
        .ex_fwd_o (ex_fwd_w),
        .commit_o (commit_o)
    );

endmodule

// ==== verification/tb_clkgen.sv ====
// Testbench clock and reset
// 8 ns clock, reset held low for the first three cycles

`timescale 1ns/100ps

module tb_clkgen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        // Release just after the edge
        #1 arst_n_o = 1'b1;
    end

endmodule

// ==== include/tb_ref_model.svh ====
// Reference model for the CPU testbench
// Encodes test instructions and predicts the commit of each one
// against a model register file, in program order

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

cpu_pkg::word_t ref_regs [cpu_pkg::NUM_REGS] = '{default: '0};

function automatic cpu_pkg::word_t enc_r(
    input cpu_pkg::funct_e     fn,
    input cpu_pkg::reg_addr_t  rs,
    input cpu_pkg::reg_addr_t  rt,
    input cpu_pkg::reg_addr_t  rd,
    input logic [4:0]          shamt
);
    cpu_pkg::inst_u w;
    w.r = '{opcode: cpu_pkg::OP_SPECIAL, rs: rs, rt: rt, rd: rd, shamt: shamt, funct: fn};
    return w;
endfunction

function automatic cpu_pkg::word_t enc_i(
    input logic [5:0]          op,
    input cpu_pkg::reg_addr_t  rs,
    input cpu_pkg::reg_addr_t  rt,
    input logic [15:0]         imm
);
    cpu_pkg::inst_u w;
    w.i = '{opcode: op, rs: rs, rt: rt, imm16: imm};
    return w;
endfunction

function automatic cpu_pkg::commit_t ref_step(
    input cpu_pkg::addr_t pc,
    input cpu_pkg::inst_u inst
);
    cpu_pkg::commit_t c;
    cpu_pkg::word_t   a;
    cpu_pkg::word_t   b;
    cpu_pkg::word_t   r;
    a = ref_regs[inst.r.rs];
    b = ref_regs[inst.r.rt];
    r = '0;
    c = '{valid: 1'b1, pc: pc, we: 1'b1, waddr: inst.r.rd, wdata: '0};
    case (inst.r.opcode)
        cpu_pkg::OP_SPECIAL: begin
            case (inst.r.funct)
                cpu_pkg::FN_SLL:  r = b << inst.r.shamt;
                cpu_pkg::FN_ADDU: r = a + b;
                cpu_pkg::FN_SUBU: r = a - b;
                cpu_pkg::FN_AND:  r = a & b;
                cpu_pkg::FN_OR:   r = a | b;
                cpu_pkg::FN_XOR:  r = a ^ b;
                cpu_pkg::FN_SLT:  r = {31'b0, $signed(a) < $signed(b)};
                default:          c.we = 1'b0;
            endcase
        end
        cpu_pkg::OP_ADDIU: r = a + {{16{inst.i.imm16[15]}}, inst.i.imm16};
        cpu_pkg::OP_ORI:   r = a | {16'h0000, inst.i.imm16};
        cpu_pkg::OP_LUI:   r = {inst.i.imm16, 16'h0000};
        default:           c.we = 1'b0;
    endcase
    if (inst.r.opcode != cpu_pkg::OP_SPECIAL) begin
        c.waddr = inst.i.rt;
    end
    if (c.waddr == '0) begin
        c.we = 1'b0;
    end
    if (c.we) begin
        ref_regs[c.waddr] = r;
    end
    c.wdata = r;
    return c;
endfunction

`endif

// ==== verification/tb_cpu.sv ====
// CPU testbench
// Random ALU program with tight dependencies, stalling instruction
// memory model, and commit-by-commit comparison with a reference model

`timescale 1ns/100ps

module tb_cpu;

    localparam int PROG_LEN    = 64;
    localparam int CYCLE_LIMIT = 400;
    localparam int STALL_FROM  = 40;
    localparam int STALL_TO    = 52;

    logic             clk;
    logic             arst_n_i;
    logic             inst_req_o;
    cpu_pkg::addr_t   inst_addr_o;
    cpu_pkg::word_t   inst_i;
    logic             inst_stall_i;
    cpu_pkg::commit_t commit_o;

    integer         seed = 11096;
    cpu_pkg::word_t prog [PROG_LEN];
    int             cycle_cnt = 0;
    int             stall_run = 0;
    int             n_commits = 0;
    logic           first_req_seen = 1'b0;

    `include "tb_ref_model.svh"

    tb_clkgen u_clkgen (
        .clk_o    (clk),
        .arst_n_o (arst_n_i)
    );

    cpu_top u_dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_req_o   (inst_req_o),
        .inst_addr_o  (inst_addr_o),
        .inst_i       (inst_i),
        .inst_stall_i (inst_stall_i),
        .commit_o     (commit_o)
    );

    ////////////////////
    // Compare tasks
    task automatic check_pc(input string name, input cpu_pkg::addr_t exp,
                            input cpu_pkg::addr_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_waddr(input string name, input cpu_pkg::reg_addr_t exp,
                               input cpu_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "write address mismatch");
        end
    endtask

    task automatic check_we(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "write enable mismatch");
        end
    endtask

    task automatic check_wdata(input string name, input cpu_pkg::word_t exp,
                               input cpu_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "write data mismatch");
        end
    endtask

    ////////////////////
    // Program generation
    function automatic cpu_pkg::word_t rand_inst();
        cpu_pkg::reg_addr_t rs;
        cpu_pkg::reg_addr_t rt;
        cpu_pkg::reg_addr_t rd;
        logic [15:0]        imm;
        int                 k;
        rs  = cpu_pkg::reg_addr_t'($random(seed) & 7);
        rt  = cpu_pkg::reg_addr_t'($random(seed) & 7);
        rd  = cpu_pkg::reg_addr_t'($random(seed) & 7);
        imm = 16'($random(seed));
        // Roughly one in sixteen is an unknown opcode
        if (($random(seed) & 15) == 0) begin
            return enc_i({1'b1, imm[4:0]}, rs, rt, imm);
        end
        k = $unsigned($random(seed)) % 10;
        case (k)
            0: return enc_r(cpu_pkg::FN_ADDU, rs, rt, rd, 5'd0);
            1: return enc_r(cpu_pkg::FN_SUBU, rs, rt, rd, 5'd0);
            2: return enc_r(cpu_pkg::FN_AND, rs, rt, rd, 5'd0);
            3: return enc_r(cpu_pkg::FN_OR, rs, rt, rd, 5'd0);
            4: return enc_r(cpu_pkg::FN_XOR, rs, rt, rd, 5'd0);
            5: return enc_r(cpu_pkg::FN_SLT, rs, rt, rd, 5'd0);
            6: return enc_r(cpu_pkg::FN_SLL, rs, rt, rd, imm[4:0]);
            7: return enc_i(cpu_pkg::OP_ADDIU, rs, rt, imm);
            8: return enc_i(cpu_pkg::OP_ORI, rs, rt, imm);
            default: return enc_i(cpu_pkg::OP_LUI, rs, rt, imm);
        endcase
    endfunction

    ////////////////////
    // Instruction memory with random stalls
    initial begin : imem_model
        cpu_pkg::addr_t off;
        int             drive_cycle;
        drive_cycle  = 0;
        inst_i       = '0;
        inst_stall_i = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = rand_inst();
        end
        @(posedge arst_n_i);
        forever begin
            @(posedge clk);
            #1;
            off = inst_addr_o - cpu_pkg::RESET_PC;
            if (off < cpu_pkg::addr_t'(PROG_LEN * cpu_pkg::INST_BYTES)) begin
                inst_i = prog[off >> 2];
            end else begin
                inst_i = '0;
            end
            // Long forced stall in the middle of the program
            if (drive_cycle >= STALL_FROM && drive_cycle < STALL_TO) begin
                inst_stall_i = 1'b1;
            end else begin
                inst_stall_i = (($random(seed) & 3) == 0);
            end
            stall_run   = inst_stall_i ? stall_run + 1 : 0;
            drive_cycle = drive_cycle + 1;
        end
    end

    ////////////////////
    // Commit checker
    always @(negedge clk) begin : commit_compare
        cpu_pkg::commit_t exp;
        string            tag;
        if (arst_n_i) begin
            // Request stays up once fetching has started
            if (first_req_seen && !inst_req_o) begin
                $display("The fetch request dropped after fetching had started");
                $display("Simulation FAILED");
                $fatal(1, "fetch request dropped");
            end
            if (inst_req_o && !first_req_seen) begin
                first_req_seen = 1'b1;
                check_pc("first fetch address", cpu_pkg::RESET_PC, inst_addr_o);
            end
            // Pipeline is empty four cycles into a stall
            if (stall_run >= 4 && commit_o.valid) begin
                $display("A commit appeared although fetch had been stalled long enough to drain");
                $display("Simulation FAILED");
                $fatal(1, "commit during stall");
            end
            if (commit_o.valid) begin
                exp = ref_step(cpu_pkg::RESET_PC + cpu_pkg::addr_t'(n_commits * 4),
                               prog[n_commits]);
                tag = $sformatf("commit %0d", n_commits);
                check_pc({tag, " pc"}, exp.pc, commit_o.pc);
                check_we({tag, " we"}, exp.we, commit_o.we);
                check_waddr({tag, " waddr"}, exp.waddr, commit_o.waddr);
                check_wdata({tag, " wdata"}, exp.wdata, commit_o.wdata);
                n_commits = n_commits + 1;
                if (n_commits == PROG_LEN) begin
                    $display("Simulation PASSED");
                    $finish;
                end
            end
        end
    end

    ////////////////////
    // Timeout
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Commits stopped after %0d of %0d instructions", n_commits, PROG_LEN);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

// ==== cpu_core.f ====
+incdir+include
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/regfile.sv
hdl/exec_stage.sv
hdl/cpu_top.sv
verification/tb_clkgen.sv
verification/tb_cpu.sv
